// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_zx_host
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
rtl/zx_pkg.sv
rtl/clock_enables.sv
rtl/memory_pager.sv
rtl/ula_port.sv
rtl/cpu_read_mux.sv
rtl/zx_host_top.sv
testbench/tb_zx_host.sv

// File: rtl/clock_enables.sv
// Clock enable generator running from clk_sys
// Gives the fixed 28 MHz, 7 MHz and PSG enables plus the CPU enables
// at the speed chosen with the turbo keys, with pause and tape override

`timescale 1ns/1ps

module clock_enables import zx_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [4:0] turbo_keys,
	input  logic       pause_key,
	input  logic       tape_active,
	output logic       ce_28m,
	output logic       ce_7mp,
	output logic       ce_7mn,
	output logic       ce_psg,
	output logic       ce_cpu_p,
	output logic       ce_cpu_n
);

	logic [5:0] counter;
	logic       cpu_tp;
	logic       cpu_tn;
	logic [4:0] turbo;
	logic [4:0] turbo_key;
	logic [4:0] turbo_req;
	logic [4:0] old_keys;
	logic [4:0] key_rise;
	logic       old_pause_key;
	logic       pause;
	logic       cpu_en;
	logic [1:0] settle;

	// ==============================
	// Divider
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			ce_28m  <= 1'b0;
			ce_7mp  <= 1'b0;
			ce_7mn  <= 1'b0;
			ce_psg  <= 1'b0;
			cpu_tp  <= 1'b0;
			cpu_tn  <= 1'b0;
		end else begin
			counter <= counter + 6'd1;
			ce_28m  <= counter[1:0] == 2'd0;
			ce_7mp  <= !counter[3] && counter[2:0] == 3'd0;
			ce_7mn  <= counter[3] && counter[2:0] == 3'd0;
			ce_psg  <= counter == 6'd0 && !pause;
			cpu_tp  <= (counter[4:0] & turbo) == 5'd0;
			// Negative strobe sits half a CPU period after the positive one
			cpu_tn  <= (counter[4:0] & turbo) == (turbo ^ {1'b0, turbo[4:1]});
		end
	end

	// ==============================
	// Turbo and pause keys
	// ==============================

	assign key_rise = turbo_keys & ~old_keys;

	always_ff @(posedge clk_sys) begin
		old_keys      <= turbo_keys;
		old_pause_key <= pause_key;
		if (reset) begin
			turbo_key <= TURBO_3M5;
			pause     <= 1'b0;
		end else begin
			// Higher key line wins when two rise together
			if (key_rise[0]) turbo_key <= TURBO_3M5;
			if (key_rise[1]) turbo_key <= TURBO_7M;
			if (key_rise[2]) turbo_key <= TURBO_14M;
			if (key_rise[3]) turbo_key <= TURBO_28M;
			if (key_rise[4]) turbo_key <= TURBO_56M;
			if (pause_key && !old_pause_key) pause <= !pause;
		end
	end

	// Tape loading needs normal speed
	assign turbo_req = tape_active ? TURBO_3M5 : turbo_key;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			turbo  <= TURBO_3M5;
			cpu_en <= 1'b0;
			settle <= '0;
		end else if (cpu_tn) begin
			if (turbo != turbo_req) begin
				turbo  <= turbo_req;
				cpu_en <= 1'b0;
				settle <= CPU_EN_SETTLE;
			end else if (settle != 2'd0) begin
				settle <= settle - 2'd1;
			end else begin
				cpu_en <= !pause;
			end
		end
	end

	assign ce_cpu_p = cpu_en & cpu_tp;
	assign ce_cpu_n = cpu_en & cpu_tn;

endmodule

// File: rtl/cpu_read_mux.sv
// CPU data input selection
// Memory wins, then the I/O ports in fixed priority, otherwise FF

`timescale 1ns/1ps

module cpu_read_mux import zx_pkg::*; (
	input  logic [15:0] addr,
	input  logic        n_mreq,
	input  logic        n_iorq,
	input  logic        n_rd,
	input  logic        n_m1,
	input  logic [7:0]  mem_dout,
	input  logic [7:0]  psg_dout,
	input  logic [4:0]  key_data,
	input  logic [7:0]  joystick,
	input  logic        tape_in,
	output logic [7:0]  cpu_din
);

	logic io_read;
	logic psg_sel;
	logic kempston_sel;

	// Interrupt acknowledge is an M1 cycle with IORQ and must not hit a port
	assign io_read      = !n_iorq && !n_rd && n_m1;
	assign psg_sel      = (addr & PSG_PORT_MASK) == PSG_PORT_MATCH;
	assign kempston_sel = addr[5:0] == KEMPSTON_PORT;

	always_comb begin
		if (!n_mreq) begin
			cpu_din = mem_dout;
		end else if (!io_read) begin
			cpu_din = IDLE_BYTE;
		end else if (kempston_sel) begin
			// Kempston reports fire and the four directions, active high
			cpu_din = {2'b00, joystick[5:0]};
		end else if (psg_sel) begin
			// Only FFFD returns register data, BFFD is write only
			cpu_din = addr[14] ? psg_dout : IDLE_BYTE;
		end else if (addr[0]) begin
			cpu_din = IDLE_BYTE;
		end else begin
			// Port FE with EAR in bit 6
			cpu_din = {1'b1, !tape_in, 1'b1, key_data};
		end
	end

endmodule

// File: rtl/memory_pager.sv
// Memory paging for the 128K, Pentagon 512K, 48K and +3 models
// Holds the 7FFD and 1FFD registers and maps the CPU address onto the
// 25-bit memory bus, ROM included, with write-protect of the ROM quarter

`timescale 1ns/1ps

module memory_pager import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic [7:0]  cpu_dout,
	input  logic        n_mreq,
	input  logic        n_rd,
	input  logic        n_wr,
	input  logic        io_wr,
	input  mem_mode_t   mem_mode,
	output mem_addr_t   mem_addr,
	output logic        mem_rd,
	output logic        mem_we,
	output logic        page_scr
);

	logic                      zx48;
	logic                      p512;
	logic                      plus3;
	bus_byte_u                 page_reg;
	bus_byte_u                 page_reg_plus3;
	logic [1:0]                page_hi;
	logic                      old_wr;
	logic                      sel_7ffd;
	logic                      sel_1ffd;
	bus_byte_u                 wr_data;
	logic                      dec_low;
	logic                      dec_7ffd;
	logic                      dec_1ffd;
	logic                      page_disable;
	logic                      page_special;
	logic [1:0]                page_cfg;
	logic [3:0]                page_rom;
	logic [4:0]                page_ram;
	logic [PAGE_SIZE_BITS-1:0] offset;

	assign offset       = addr[PAGE_SIZE_BITS-1:0];
	assign page_disable = zx48 | page_reg.pg128.lock;
	assign page_special = page_reg_plus3.pgp3.special;
	assign page_cfg     = page_reg_plus3.pgp3.cfg;
	assign page_scr     = page_reg.pg128.screen;
	assign page_ram     = {page_hi, page_reg.pg128.bank};

	// ==============================
	// Port decode and write pipeline
	// ==============================

	assign dec_low  = (addr & PORT_7FFD_MASK_BITS) == 16'h0000;
	// On the +3, 7FFD also needs A14 so that it stays clear of 1FFD
	assign dec_7ffd = dec_low && (addr[14] || !plus3);
	assign dec_1ffd = dec_low && addr[PORT_1FFD] && addr[14:13] == 2'b00 && plus3;

	always_ff @(posedge clk_sys) begin
		old_wr <= io_wr;
		if (io_wr && !old_wr) wr_data <= cpu_dout;
		if (reset) begin
			sel_7ffd <= 1'b0;
			sel_1ffd <= 1'b0;
		end else begin
			sel_7ffd <= io_wr && !old_wr && dec_7ffd;
			sel_1ffd <= io_wr && !old_wr && dec_1ffd;
		end
	end

	// Model flags follow mem_mode for as long as reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg       <= '0;
			page_reg_plus3 <= '0;
			page_hi        <= '0;
			zx48           <= mem_mode == MODE_48;
			p512           <= mem_mode == MODE_P512;
			plus3          <= mem_mode == MODE_PLUS3;
		end else if (!page_disable) begin
			if (sel_7ffd) begin
				page_reg <= wr_data;
				if (p512) page_hi <= wr_data.pg128.high_bank;
			end
			if (sel_1ffd) page_reg_plus3 <= wr_data;
		end
	end

	// ==============================
	// Address mapping
	// ==============================

	always_comb begin
		if (plus3) begin
			page_rom = {2'b01, page_reg_plus3.pgp3.rom_hi, page_reg.pg128.rom};
		end else begin
			page_rom = {3'b001, zx48 | page_reg.pg128.rom};
		end

		if (!page_special) begin
			case (addr[15:14])
				2'd0:    mem_addr = ROM_BASE + mem_addr_t'({page_rom, offset});
				2'd1:    mem_addr = mem_addr_t'({3'd5, offset});
				2'd2:    mem_addr = mem_addr_t'({3'd2, offset});
				default: mem_addr = mem_addr_t'({page_ram, offset});
			endcase
		end else begin
			// All-RAM layouts 0123, 4567, 4563 and 4763
			case (addr[15:14])
				2'd0:    mem_addr = mem_addr_t'({|page_cfg, 2'b00, offset});
				2'd1:    mem_addr = mem_addr_t'({|page_cfg, &page_cfg, 1'b1, offset});
				2'd2:    mem_addr = mem_addr_t'({|page_cfg, 2'b10, offset});
				default: mem_addr = mem_addr_t'({!page_cfg[1] & page_cfg[0], 2'b11, offset});
			endcase
		end
	end

	assign mem_rd = !n_mreq && !n_rd;
	// ROM quarter is read only unless an all-RAM layout is active
	assign mem_we = (page_special || addr[15] || addr[14]) && !n_mreq && !n_wr;

endmodule

// File: rtl/ula_port.sv
// ULA output port and audio mixer
// Latches border, EAR and MIC on even port writes and mixes them with
// the tape input and the PSG channels into left and right words

`timescale 1ns/1ps

module ula_port import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        addr0,
	input  logic [7:0]  cpu_dout,
	input  logic        io_wr,
	input  logic        tape_in,
	input  logic [7:0]  psg_ch_a,
	input  logic [7:0]  psg_ch_b,
	input  logic [7:0]  psg_ch_c,
	output logic [2:0]  border_color,
	output logic [15:0] audio_l,
	output logic [15:0] audio_r
);

	logic       old_wr;
	logic       ula_wr;
	bus_byte_u  wr_data;
	logic       ear;
	logic       mic;
	logic [9:0] beeper;

	// Outer channel counts double, B is shared by both sides
	function automatic logic [9:0] mix(input logic [7:0] outer, input logic [7:0] mid,
			input logic [9:0] beep);
		mix = {1'b0, outer, 1'b0} + {2'b00, mid} + beep;
	endfunction

	always_ff @(posedge clk_sys) begin
		old_wr <= io_wr;
		if (io_wr && !old_wr) wr_data <= cpu_dout;
		if (reset) begin
			ula_wr <= 1'b0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else begin
			ula_wr <= io_wr && !old_wr && !addr0;
			if (ula_wr) begin
				ear <= wr_data.ula.ear;
				mic <= wr_data.ula.mic;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ula_wr) border_color <= wr_data.ula.border;
	end

	assign beeper  = {2'b00, ear, mic, tape_in, 5'b00000};
	assign audio_l = {mix(psg_ch_a, psg_ch_b, beeper), 6'd0};
	assign audio_r = {mix(psg_ch_c, psg_ch_b, beeper), 6'd0};

endmodule

// File: rtl/zx_host_top.sv
// Spectrum host board glue, top level
// Sits between an external Z80, PSG and memory device, and
// decodes the shared I/O strobes for the paging, ULA and read blocks

`timescale 1ns/1ps

module zx_host_top import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	// Z80 bus
	input  logic [15:0] addr,
	input  logic [7:0]  cpu_dout,
	input  logic        n_mreq,
	input  logic        n_iorq,
	input  logic        n_rd,
	input  logic        n_wr,
	input  logic        n_m1,
	output logic [7:0]  cpu_din,
	// Memory device
	input  mem_mode_t   mem_mode,
	input  logic [7:0]  mem_dout,
	output mem_addr_t   mem_addr,
	output logic        mem_rd,
	output logic        mem_we,
	// Keys, tape and joystick
	input  logic [4:0]  turbo_keys,
	input  logic        pause_key,
	input  logic        tape_active,
	input  logic        tape_in,
	input  logic [4:0]  key_data,
	input  logic [7:0]  joystick,
	// PSG
	input  logic [7:0]  psg_dout,
	input  logic [7:0]  psg_ch_a,
	input  logic [7:0]  psg_ch_b,
	input  logic [7:0]  psg_ch_c,
	output logic        psg_we,
	output logic        psg_bc,
	// Enables, border and audio
	output logic        ce_28m,
	output logic        ce_7mp,
	output logic        ce_7mn,
	output logic        ce_psg,
	output logic        ce_cpu_p,
	output logic        ce_cpu_n,
	output logic [2:0]  border_color,
	output logic [15:0] audio_l,
	output logic [15:0] audio_r
);

	logic io_wr;
	logic io_rd;
	logic psg_sel;

	// ==============================
	// Bus strobes
	// ==============================

	assign io_wr   = !n_iorq && !n_wr && n_m1;
	assign io_rd   = !n_iorq && !n_rd && n_m1;
	assign psg_sel = (addr & PSG_PORT_MASK) == PSG_PORT_MATCH;

	// BDIR/BC pair: FFFD write latches address, FFFD read returns data
	assign psg_we = psg_sel && io_wr;
	assign psg_bc = psg_sel && addr[14] && (io_wr || io_rd);

	clock_enables u_clock_enables (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.turbo_keys  (turbo_keys),
		.pause_key   (pause_key),
		.tape_active (tape_active),
		.ce_28m      (ce_28m),
		.ce_7mp      (ce_7mp),
		.ce_7mn      (ce_7mn),
		.ce_psg      (ce_psg),
		.ce_cpu_p    (ce_cpu_p),
		.ce_cpu_n    (ce_cpu_n)
	);

	// Screen select is for the video block, which lives outside this board glue
	memory_pager u_memory_pager (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.addr     (addr),
		.cpu_dout (cpu_dout),
		.n_mreq   (n_mreq),
		.n_rd     (n_rd),
		.n_wr     (n_wr),
		.io_wr    (io_wr),
		.mem_mode (mem_mode),
		.mem_addr (mem_addr),
		.mem_rd   (mem_rd),
		.mem_we   (mem_we),
		.page_scr ()
	);

	ula_port u_ula_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr0        (addr[0]),
		.cpu_dout     (cpu_dout),
		.io_wr        (io_wr),
		.tape_in      (tape_in),
		.psg_ch_a     (psg_ch_a),
		.psg_ch_b     (psg_ch_b),
		.psg_ch_c     (psg_ch_c),
		.border_color (border_color),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	cpu_read_mux u_cpu_read_mux (
		.addr     (addr),
		.n_mreq   (n_mreq),
		.n_iorq   (n_iorq),
		.n_rd     (n_rd),
		.n_m1     (n_m1),
		.mem_dout (mem_dout),
		.psg_dout (psg_dout),
		.key_data (key_data),
		.joystick (joystick),
		.tape_in  (tape_in),
		.cpu_din  (cpu_din)
	);

endmodule

// File: rtl/zx_pkg.sv
// Shared constants and types for the Spectrum host glue
// Imported by every RTL block and by the testbench

package zx_pkg;

	// ==============================
	// Memory layout
	// ==============================

	typedef logic [24:0] mem_addr_t;

	// ROM region, upper bits 1000 sit at address bits 21:18
	localparam mem_addr_t ROM_BASE = 25'h020_0000;

	// Offset width inside one 16 KB page
	localparam int PAGE_SIZE_BITS = 14;

	// ==============================
	// Port decode
	// ==============================

	// Address lines that must be low for 7FFD (A15 and A1)
	localparam logic [15:0] PORT_7FFD_MASK_BITS = 16'h8002;
	// Address line that picks 1FFD over 7FFD on the +3
	localparam int PORT_1FFD = 12;

	// PSG ports FFFD and BFFD need A15 and A0 high with A1 low
	localparam logic [15:0] PSG_PORT_MASK = 16'h8003;
	localparam logic [15:0] PSG_PORT_MATCH = 16'h8001;

	localparam logic [5:0] KEMPSTON_PORT = 6'h1F;

	// Value seen by the CPU when nothing drives the bus
	localparam logic [7:0] IDLE_BYTE = 8'hFF;

	// Memory model, code 2 is reserved and behaves as 128K
	typedef enum logic [2:0] {
		MODE_128   = 3'd0,
		MODE_P512  = 3'd1,
		MODE_48    = 3'd3,
		MODE_PLUS3 = 3'd4
	} mem_mode_t;

	// ==============================
	// CPU speed
	// ==============================

	// Divider masks, a CPU strobe fires when counter & mask is zero
	localparam logic [4:0] TURBO_3M5 = 5'b11111;
	localparam logic [4:0] TURBO_7M  = 5'b01111;
	localparam logic [4:0] TURBO_14M = 5'b00111;
	localparam logic [4:0] TURBO_28M = 5'b00011;
	localparam logic [4:0] TURBO_56M = 5'b00001;

	// Negative CPU strobes to wait after a speed change
	localparam logic [1:0] CPU_EN_SETTLE = 2'd3;

	// One CPU data byte seen as a 7FFD, 1FFD or ULA port write
	typedef union packed {
		struct packed {
			logic [1:0] high_bank;
			logic       lock;
			logic       rom;
			logic       screen;
			logic [2:0] bank;
		} pg128;
		struct packed {
			logic [3:0] other;
			logic       rom_hi;
			logic [1:0] cfg;
			logic       special;
		} pgp3;
		struct packed {
			logic [2:0] unused;
			logic       ear;
			logic       mic;
			logic [2:0] border;
		} ula;
	} bus_byte_u;

endpackage

// File: testbench/tb_zx_host.sv
// Testbench for the Spectrum host glue
// Drives the Z80 bus, keys and PSG lines, keeps a reference model of
// the paging and ULA registers and compares the DUT outputs every cycle

`timescale 1ns/1ps

module tb_zx_host import zx_pkg::*; ();

	// Enable and turbo windows counted as 4 x 64 cycles per turbo setting
	// and bus steps as 200 operations of 8 cycles, both doubled, plus a margin
	localparam int TIMEOUT_CYCLES = 4 * 64 * 5 * 2 + 200 * 8 * 2 + 2000;

	logic        clk_sys;
	logic        reset;
	logic [15:0] addr;
	logic [7:0]  cpu_dout;
	logic        n_mreq, n_iorq, n_rd, n_wr, n_m1;
	mem_mode_t   mem_mode;
	logic [7:0]  mem_dout;
	logic [4:0]  turbo_keys;
	logic        pause_key, tape_active, tape_in;
	logic [4:0]  key_data;
	logic [7:0]  joystick, psg_dout, psg_ch_a, psg_ch_b, psg_ch_c;
	logic        ce_28m, ce_7mp, ce_7mn, ce_psg, ce_cpu_p, ce_cpu_n;
	logic [7:0]  cpu_din;
	mem_addr_t   mem_addr;
	logic        mem_rd, mem_we, psg_we, psg_bc;
	logic [2:0]  border_color;
	logic [15:0] audio_l, audio_r;

	// Reference model state
	mem_mode_t   m_mode;
	logic [7:0]  m_7ffd, m_1ffd;
	logic [1:0]  m_hi;
	logic        m_ear, m_mic;
	logic [2:0]  m_border;
	logic        border_valid;
	logic        started;
	logic [31:0] rng;
	int          cycles;
	int          errors;

	zx_host_top dut_i (.*);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	// ==============================
	// Reference functions
	// ==============================

	function automatic mem_addr_t ref_mem_addr(input logic [15:0] a);
		logic [15:0] layout;
		logic [3:0]  bank;
		logic [3:0]  rom_page;
		if (m_1ffd[0]) begin
			case (m_1ffd[2:1])
				2'd0:    layout = 16'h0123;
				2'd1:    layout = 16'h4567;
				2'd2:    layout = 16'h4563;
				default: layout = 16'h4763;
			endcase
			bank = layout[4 * (3 - a[15:14]) +: 4];
			return mem_addr_t'({bank, a[13:0]});
		end
		if (m_mode == MODE_PLUS3)
			rom_page = {2'b01, m_1ffd[3], m_7ffd[4]};
		else
			rom_page = {3'b001, (m_mode == MODE_48) | m_7ffd[4]};
		case (a[15:14])
			2'd0:    return ROM_BASE + mem_addr_t'({rom_page, a[13:0]});
			2'd1:    return mem_addr_t'({3'd5, a[13:0]});
			2'd2:    return mem_addr_t'({3'd2, a[13:0]});
			default: return mem_addr_t'({m_hi, m_7ffd[2:0], a[13:0]});
		endcase
	endfunction

	function automatic logic [7:0] ref_cpu_din(input logic [15:0] a);
		if (!n_mreq) return mem_dout;
		if (n_iorq || n_rd || !n_m1) return IDLE_BYTE;
		if (a[5:0] == 6'h1F) return {2'b00, joystick[5:0]};
		if (a[15] && a[0] && !a[1]) return a[14] ? psg_dout : 8'hFF;
		if (a[0]) return 8'hFF;
		return {1'b1, !tape_in, 1'b1, key_data};
	endfunction

	function automatic logic [15:0] ref_audio(input logic [7:0] outer, input logic [7:0] mid);
		int sum;
		sum = 2 * outer + mid + 32 * (4 * m_ear + 2 * m_mic + tape_in);
		return 16'(sum << 6);
	endfunction

	// AY control pair, BDIR on any PSG port write and BC1 on FFFD accesses
	function automatic logic [1:0] psg_bus_ctrl(input logic [15:0] a);
		logic psg_port;
		logic io_cycle;
		psg_port = a[15] && a[0] && !a[1];
		io_cycle = !n_iorq && n_m1;
		return {psg_port && io_cycle && !n_wr,
			psg_port && io_cycle && a[14] && (!n_wr || !n_rd)};
	endfunction

	// Outputs are compared at the falling edge where they are stable
	always @(negedge clk_sys) begin
		if (started && !reset) begin
			check("mem_addr", mem_addr, ref_mem_addr(addr));
			check("mem_rd", mem_rd, !n_mreq && !n_rd);
			check("mem_we", mem_we, !n_mreq && !n_wr && (m_1ffd[0] || addr[15:14] != 0));
			check("cpu_din", cpu_din, ref_cpu_din(addr));
			check("psg_we and psg_bc", {psg_we, psg_bc}, psg_bus_ctrl(addr));
			check("audio_l", audio_l, ref_audio(psg_ch_a, psg_ch_b));
			check("audio_r", audio_r, ref_audio(psg_ch_c, psg_ch_b));
			if (border_valid) check("border_color", border_color, m_border);
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

	// ==============================
	// Stimulus tasks
	// ==============================

	task automatic do_reset(input mem_mode_t m);
		@(posedge clk_sys);
		reset    <= 1'b1;
		mem_mode <= m;
		m_mode = m;
		m_7ffd = '0;
		m_1ffd = '0;
		m_hi   = '0;
		m_ear  = 1'b0;
		m_mic  = 1'b0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		started = 1'b1;
	endtask

	// Write lands two cycles after the strobe rises and the bus is released then
	task automatic io_write(input logic [15:0] port, input logic [7:0] d);
		@(posedge clk_sys);
		addr     <= port;
		cpu_dout <= d;
		n_iorq   <= 1'b0;
		n_wr     <= 1'b0;
		@(posedge clk_sys);
		@(posedge clk_sys);
		n_iorq <= 1'b1;
		n_wr   <= 1'b1;
	endtask

	task automatic write_7ffd(input logic [7:0] d);
		io_write(16'h7FFD, d);
		if (m_mode != MODE_48 && !m_7ffd[5]) begin
			m_7ffd = d;
			if (m_mode == MODE_P512) m_hi = d[7:6];
		end
	endtask

	task automatic write_1ffd(input logic [7:0] d);
		io_write(16'h1FFD, d);
		if (!m_7ffd[5]) m_1ffd = d;
	endtask

	task automatic mem_access();
		rng = xorshift(rng);
		@(posedge clk_sys);
		addr     <= rng[15:0];
		mem_dout <= rng[23:16];
		n_mreq   <= 1'b0;
		n_rd     <= rng[24];
		n_wr     <= !rng[24];
		@(posedge clk_sys);
		n_mreq <= 1'b1;
		n_rd   <= 1'b1;
		n_wr   <= 1'b1;
	endtask

	task automatic pulse(input int key);
		@(posedge clk_sys);
		if (key < 0) begin
			pause_key <= 1'b1;
		end else begin
			turbo_keys <= 5'b00001 << key;
		end
		@(posedge clk_sys);
		pause_key  <= 1'b0;
		turbo_keys <= '0;
	endtask

	task automatic count_enables(input int n, output int n28, output int n7p, output int n7n,
			output int npsg, output int ncpu, output int ncpun);
		n28 = 0;
		n7p = 0;
		n7n = 0;
		npsg = 0;
		ncpu = 0;
		ncpun = 0;
		repeat (n) begin
			@(negedge clk_sys);
			n28 += ce_28m;
			n7p += ce_7mp;
			n7n += ce_7mn;
			npsg += ce_psg;
			ncpu += ce_cpu_p;
			ncpun += ce_cpu_n;
		end
	endtask

	task automatic check_turbo(input int key, input logic tape, input logic [4:0] mask);
		int a, b, c, d, ncpu, ncpun;
		@(posedge clk_sys);
		tape_active <= tape;
		if (key >= 0) pulse(key);
		repeat (256) @(posedge clk_sys);
		count_enables(32, a, b, c, d, ncpu, ncpun);
		check("ce_cpu_p per 32 cycles", ncpu, 32 / (mask + 1));
		check("ce_cpu_n per 32 cycles", ncpun, 32 / (mask + 1));
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		int n28, n7p, n7n, npsg, ncpu, ncpun;
		logic [15:0] port;
		reset = 1'b1;
		addr = '0;
		cpu_dout = '0;
		n_mreq = 1'b1;
		n_iorq = 1'b1;
		n_rd = 1'b1;
		n_wr = 1'b1;
		n_m1 = 1'b1;
		mem_mode = MODE_128;
		mem_dout = '0;
		turbo_keys = '0;
		pause_key = 1'b0;
		tape_active = 1'b0;
		tape_in = 1'b0;
		key_data = '0;
		joystick = '0;
		psg_dout = '0;
		psg_ch_a = '0;
		psg_ch_b = '0;
		psg_ch_c = '0;
		rng = 32'h2e8a1257;
		cycles = 0;
		errors = 0;
		started = 1'b0;
		border_valid = 1'b0;

		// Fixed enable rates and pause
		do_reset(MODE_128);
		repeat (8) @(posedge clk_sys);
		count_enables(64, n28, n7p, n7n, npsg, ncpu, ncpun);
		check("ce_28m per 64", n28, 16);
		check("ce_7mp per 64", n7p, 4);
		check("ce_7mn per 64", n7n, 4);
		check("ce_psg per 64", npsg, 1);
		pulse(-1);
		count_enables(64, n28, n7p, n7n, npsg, ncpu, ncpun);
		check("ce_psg per 64 while paused", npsg, 0);
		pulse(-1);
		count_enables(64, n28, n7p, n7n, npsg, ncpu, ncpun);
		check("ce_psg per 64 after pause", npsg, 1);

		// Turbo keys and the tape override
		check_turbo(1, 1'b0, TURBO_7M);
		check_turbo(2, 1'b0, TURBO_14M);
		check_turbo(3, 1'b0, TURBO_28M);
		check_turbo(4, 1'b0, TURBO_56M);
		check_turbo(-1, 1'b1, TURBO_3M5);
		check_turbo(-1, 1'b0, TURBO_56M);
		check_turbo(0, 1'b0, TURBO_3M5);

		// 128K paging and the lock bit
		for (int i = 0; i < 40; i++) begin
			rng = xorshift(rng);
			write_7ffd(rng[7:0] & 8'hDF);
			repeat (3) mem_access();
		end
		write_7ffd(8'h27);
		for (int i = 0; i < 5; i++) begin
			rng = xorshift(rng);
			write_7ffd(rng[7:0]);
			repeat (2) mem_access();
		end

		// +3 special layouts and rom_hi
		do_reset(MODE_PLUS3);
		for (int i = 0; i < 30; i++) begin
			rng = xorshift(rng);
			write_1ffd(rng[7:0]);
			write_7ffd(rng[15:8] & 8'hDF);
			repeat (3) mem_access();
		end

		// Pentagon 512K high bank bits
		do_reset(MODE_P512);
		for (int i = 0; i < 30; i++) begin
			rng = xorshift(rng);
			write_7ffd(rng[7:0] & 8'hDF);
			repeat (3) mem_access();
		end

		// 48K keeps paging frozen
		do_reset(MODE_48);
		write_7ffd(8'h07);
		repeat (4) mem_access();

		// Port reads through the read mux
		for (int i = 0; i < 100; i++) begin
			rng = xorshift(rng);
			port = rng[15:0];
			if (rng[31:30] == 2'b00) port[5:0] = 6'h1F;
			@(posedge clk_sys);
			addr     <= port;
			n_iorq   <= 1'b0;
			n_rd     <= 1'b0;
			n_m1     <= rng[29:27] != 3'd0;
			key_data <= rng[20:16];
			tape_in  <= rng[21];
			rng = xorshift(rng);
			joystick <= rng[7:0];
			psg_dout <= rng[15:8];
			@(posedge clk_sys);
			n_iorq <= 1'b1;
			n_rd   <= 1'b1;
			n_m1   <= 1'b1;
		end

		// ULA port writes and audio
		for (int i = 0; i < 30; i++) begin
			rng = xorshift(rng);
			psg_ch_a <= rng[7:0];
			psg_ch_b <= rng[15:8];
			psg_ch_c <= rng[23:16];
			tape_in  <= rng[24];
			rng = xorshift(rng);
			io_write((rng[15:0] & 16'hFFFE) | 16'h8000, rng[23:16]);
			m_border = rng[18:16];
			m_mic = rng[19];
			m_ear = rng[20];
			border_valid = 1'b1;
			// PSG register select or data write, ignored by the ULA
			rng = xorshift(rng);
			io_write((rng[15:0] & 16'hFFFD) | 16'h8001, rng[23:16]);
		end
		repeat (4) @(posedge clk_sys);

		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
